// ==== fpu_pkg.sv ====
/*
  fp16 pair unit shared definitions
  opcodes, half-precision field widths, compare flag positions and
  the pipeline depth used by control and the checker
*/
package fpu_pkg;

  //////////////////////////////
  // opcodes
  //////////////////////////////
  typedef enum logic [1:0] {
    OP_ADD    = 2'd0,
    OP_SUB    = 2'd1,
    OP_CMP_LO = 2'd2, // flags from bits 15..0
    OP_CMP_HI = 2'd3  // flags from bits 31..16
  } fpu_op_e;

  //////////////////////////////
  // fp16 format
  //////////////////////////////
  localparam int FP_EXP_W = 5;
  localparam int FP_MAN_W = 10;
  localparam int FP_W     = 16;

  localparam int GUARD_W  = 3;  // extra bits kept below the mantissa while aligning

  // hidden bit + mantissa + guard
  localparam int MAG_W    = FP_MAN_W + 1 + GUARD_W;

  localparam int WORD_W   = 32; // two lanes with the low lane in 15..0

  //////////////////////////////
  // compare flags
  //////////////////////////////
  localparam int FLAG_W  = 3;
  localparam int FLAG_EQ = 0;
  localparam int FLAG_LT = 1;
  localparam int FLAG_GT = 2;

  // register stages from operand capture to result
  localparam int LAT = 3;

endpackage

// ==== fp16_align.sv ====
/*
  fp16 operand alignment
  unpacks both operands, orders them by magnitude and shifts the smaller
  mantissa down to the larger exponent; also compares a against b
*/
module fp16_align import fpu_pkg::*; (
  input  logic [FP_W-1:0]     a,
  input  logic [FP_W-1:0]     b,
  input  logic                sub,
  output logic                big_sign,
  output logic                eff_sub,
  output logic [FP_EXP_W-1:0] big_exp,
  output logic [MAG_W-1:0]    big_man,
  output logic [MAG_W-1:0]    small_man,
  output logic [FLAG_W-1:0]   cmp
);

  logic                a_zero;
  logic                b_zero;
  logic                a_sign;    // zero counts as positive
  logic                b_sign;
  logic                b_op_sign; // b sign as seen by the adder
  logic [FP_EXP_W-1:0] a_exp;
  logic [FP_EXP_W-1:0] b_exp;
  logic [FP_W-2:0]     a_mag;
  logic [FP_W-2:0]     b_mag;
  logic [MAG_W-1:0]    a_full;
  logic [MAG_W-1:0]    b_full;
  logic                swap;
  logic [FP_EXP_W-1:0] small_exp;
  logic [FP_EXP_W-1:0] exp_diff;
  logic [MAG_W-1:0]    small_full;
  logic                eq;
  logic                lt;

  //////////////////////////////
  // unpack
  //////////////////////////////
  assign a_exp  = a[FP_W-2 -: FP_EXP_W];
  assign b_exp  = b[FP_W-2 -: FP_EXP_W];
  assign a_zero = (a_exp == '0); // denormals read as zero
  assign b_zero = (b_exp == '0);

  assign a_sign    = a[FP_W-1] & ~a_zero;
  assign b_sign    = b[FP_W-1] & ~b_zero;
  assign b_op_sign = b_sign ^ sub;

  assign a_mag = a_zero ? '0 : a[FP_W-2:0];
  assign b_mag = b_zero ? '0 : b[FP_W-2:0];

  assign a_full = a_zero ? '0 : {1'b1, a[FP_MAN_W-1:0], {GUARD_W{1'b0}}};
  assign b_full = b_zero ? '0 : {1'b1, b[FP_MAN_W-1:0], {GUARD_W{1'b0}}};

  //////////////////////////////
  // order and align
  //////////////////////////////
  // exp:man as one field orders magnitudes directly; ties keep a on top
  assign swap = (b_mag > a_mag);

  assign big_sign   = swap ? b_op_sign : a_sign;
  assign eff_sub    = a_sign ^ b_op_sign;
  assign big_exp    = swap ? b_exp : a_exp;
  assign small_exp  = swap ? a_exp : b_exp;
  assign big_man    = swap ? b_full : a_full;
  assign small_full = swap ? a_full : b_full;

  assign exp_diff  = big_exp - small_exp;
  assign small_man = small_full >> exp_diff; // bits below guard are lost, no sticky

  //////////////////////////////
  // compare
  //////////////////////////////
  // cleared zero signs make +0 and -0 equal
  assign eq = (a_sign == b_sign) && (a_mag == b_mag);

  always_comb begin
    if (a_sign != b_sign) begin
      lt = a_sign;
    end else if (a_sign) begin
      lt = (a_mag > b_mag); // both negative, larger magnitude is smaller
    end else begin
      lt = (a_mag < b_mag);
    end
  end

  always_comb begin
    cmp          = '0;
    cmp[FLAG_EQ] = eq;
    cmp[FLAG_LT] = lt;
    cmp[FLAG_GT] = ~eq & ~lt;
  end

endmodule

// ==== fp16_normalize.sv ====
/*
  fp16 result normalization and packing
  leading-one search, exponent adjust, truncation, flush to zero and
  saturation to infinity
*/
module fp16_normalize import fpu_pkg::*; (
  input  logic                sign,
  input  logic [FP_EXP_W-1:0] exp,
  input  logic [MAG_W:0]      sum,    // carry bit on top
  output logic [FP_W-1:0]     result,
  output logic                ovf
);

  localparam int EXP_E_W = FP_EXP_W + 2;                 // room for sign and carry
  localparam logic [FP_EXP_W-1:0] EXP_INF = '1;
  localparam int EXP_MAX = (1 << FP_EXP_W) - 2;          // largest exponent kept

  logic [3:0]         lzc;
  logic [MAG_W:0]     norm;
  logic signed [EXP_E_W-1:0] exp_adj;

  //////////////////////////////
  // leading zeros below carry
  //////////////////////////////
  always_comb begin
    lzc = 4'(MAG_W); // all zero
    for (int i = 0; i < MAG_W; i++) begin
      if (sum[i]) begin
        lzc = 4'(MAG_W - 1 - i); // last hit is the top one
      end
    end
  end

  //////////////////////////////
  // shift and exponent adjust
  //////////////////////////////
  always_comb begin
    if (sum[MAG_W]) begin
      norm    = sum >> 1;
      exp_adj = $signed({2'b00, exp}) + 7'sd1;
    end else begin
      norm    = sum << lzc;
      exp_adj = $signed({2'b00, exp}) - $signed({3'b000, lzc});
    end
  end

  //////////////////////////////
  // pack
  //////////////////////////////
  always_comb begin
    ovf = 1'b0;
    if (sum == '0) begin
      result = '0; // exact zero is always +0
    end else if (exp_adj < 1) begin
      result = {sign, {(FP_W-1){1'b0}}};
    end else if (exp_adj > EXP_MAX) begin
      result = {sign, EXP_INF, {FP_MAN_W{1'b0}}};
      ovf    = 1'b1;
    end else begin
      // guard bits dropped, i.e. round toward zero
      result = {sign, exp_adj[FP_EXP_W-1:0], norm[MAG_W-2 -: FP_MAN_W]};
    end
  end

endmodule

// ==== fp16_lane.sv ====
/*
  fp16 add/sub lane
  three register stages: aligned operands, raw magnitude, packed result
*/
module fp16_lane import fpu_pkg::*; (
  input  logic              clk,
  input  logic [FP_W-1:0]   a,
  input  logic [FP_W-1:0]   b,
  input  logic              sub,
  output logic [FP_W-1:0]   result,
  output logic [FLAG_W-1:0] cmp,
  output logic              ovf
);

  logic                al_sign;
  logic                al_eff_sub;
  logic [FP_EXP_W-1:0] al_exp;
  logic [MAG_W-1:0]    al_big;
  logic [MAG_W-1:0]    al_small;
  logic [FLAG_W-1:0]   al_cmp;

  logic                s1_sign;
  logic                s1_eff_sub;
  logic [FP_EXP_W-1:0] s1_exp;
  logic [MAG_W-1:0]    s1_big;
  logic [MAG_W-1:0]    s1_small;
  logic [FLAG_W-1:0]   s1_cmp;

  logic                s2_sign;
  logic [FP_EXP_W-1:0] s2_exp;
  logic [MAG_W:0]      s2_sum;
  logic [FLAG_W-1:0]   s2_cmp;

  logic [FP_W-1:0]     nrm_result;
  logic                nrm_ovf;

  fp16_align i_align (
    .a         (a),
    .b         (b),
    .sub       (sub),
    .big_sign  (al_sign),
    .eff_sub   (al_eff_sub),
    .big_exp   (al_exp),
    .big_man   (al_big),
    .small_man (al_small),
    .cmp       (al_cmp)
  );

  //////////////////////////////
  // stages 1 and 2
  //////////////////////////////
  always_ff @(posedge clk) begin
    s1_sign    <= al_sign;
    s1_eff_sub <= al_eff_sub;
    s1_exp     <= al_exp;
    s1_big     <= al_big;
    s1_small   <= al_small;
    s1_cmp     <= al_cmp;

    // big >= small after ordering, so the difference never goes negative
    s2_sum  <= s1_eff_sub ? ({1'b0, s1_big} - {1'b0, s1_small})
                          : ({1'b0, s1_big} + {1'b0, s1_small});
    s2_sign <= s1_sign;
    s2_exp  <= s1_exp;
    s2_cmp  <= s1_cmp;
  end

  fp16_normalize i_normalize (
    .sign   (s2_sign),
    .exp    (s2_exp),
    .sum    (s2_sum),
    .result (nrm_result),
    .ovf    (nrm_ovf)
  );

  // stage 3
  always_ff @(posedge clk) begin
    result <= nrm_result;
    ovf    <= nrm_ovf;
    cmp    <= s2_cmp;
  end

endmodule

// ==== fpu_ctrl.sv ====
/*
  fp16 pair control
  opcode decode, valid/op delay chain beside the lanes and selection of
  the compare flags from the low or high lane
*/
module fpu_ctrl import fpu_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              in_valid,
  input  fpu_op_e           op,
  input  logic [FLAG_W-1:0] cmp_lo,
  input  logic [FLAG_W-1:0] cmp_hi,
  output logic              sub,
  output logic              out_valid,
  output logic [FLAG_W-1:0] flags
);

  logic [LAT-1:0] valid_q;
  fpu_op_e        op_q [LAT];

  // compares run through the lanes as a - b
  assign sub = (op != OP_ADD);

  //////////////////////////////
  // delay chain
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
    end else begin
      valid_q <= {valid_q[LAT-2:0], in_valid};
    end
  end

  always_ff @(posedge clk) begin
    op_q[0] <= op;
    for (int i = 1; i < LAT; i++) begin
      op_q[i] <= op_q[i-1];
    end
  end

  assign out_valid = valid_q[LAT-1];

  //////////////////////////////
  // flag select
  //////////////////////////////
  always_comb begin
    case (op_q[LAT-1])
      OP_CMP_LO: flags = cmp_lo;
      OP_CMP_HI: flags = cmp_hi;
      default:   flags = '0; // add/sub report no flags
    endcase
  end

endmodule

// ==== fpu_pair_top.sv ====
/*
  packed fp16 pair execute unit
  two lanes over the halves of each word plus shared control
*/
module fpu_pair_top import fpu_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              in_valid,
  input  fpu_op_e           op,
  input  logic [WORD_W-1:0] a,
  input  logic [WORD_W-1:0] b,
  output logic              out_valid,
  output logic [WORD_W-1:0] result,
  output logic [FLAG_W-1:0] flags,
  output logic [1:0]        ovf
);

  logic              sub;
  logic [FLAG_W-1:0] cmp_lo;
  logic [FLAG_W-1:0] cmp_hi;

  fpu_ctrl i_ctrl (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .op        (op),
    .cmp_lo    (cmp_lo),
    .cmp_hi    (cmp_hi),
    .sub       (sub),
    .out_valid (out_valid),
    .flags     (flags)
  );

  // bits 15..0
  fp16_lane lane_lo (
    .clk    (clk),
    .a      (a[FP_W-1:0]),
    .b      (b[FP_W-1:0]),
    .sub    (sub),
    .result (result[FP_W-1:0]),
    .cmp    (cmp_lo),
    .ovf    (ovf[0])
  );

  // bits 31..16
  fp16_lane lane_hi (
    .clk    (clk),
    .a      (a[WORD_W-1:FP_W]),
    .b      (b[WORD_W-1:FP_W]),
    .sub    (sub),
    .result (result[WORD_W-1:FP_W]),
    .cmp    (cmp_hi),
    .ovf    (ovf[1])
  );

endmodule

// ==== tb_clock.sv ====
/*
  testbench clock and reset
  period 8, reset held over the first two rising edges
*/
module tb_clock (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst <= 1'b0; // released on a falling edge like every other input
  end

endmodule

// ==== fpu_checker.sv ====
/*
  fp16 pair checker
  reference model, expected-result queue, latency and value checks
*/
module fpu_checker import fpu_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic [3:0]        test_id,
  input  logic              in_valid,
  input  fpu_op_e           op,
  input  logic [WORD_W-1:0] a,
  input  logic [WORD_W-1:0] b,
  input  logic              out_valid,
  input  logic [WORD_W-1:0] result,
  input  logic [FLAG_W-1:0] flags,
  input  logic [1:0]        ovf,
  output int                mismatch_count,
  output int                protocol_count,
  output int                pending
);

  logic [36:0] exp_q [$]; // result, flags, ovf
  int          due_q [$];
  logic [3:0]  id_q [$];
  int          cyc = 0;
  int          n_mismatch = 0;
  int          n_protocol = 0;
  int          n_pending = 0;
  bit          rst_seen = 1'b0;

  assign mismatch_count = n_mismatch;
  assign protocol_count = n_protocol;
  assign pending        = n_pending;

  function automatic string test_name(input logic [3:0] id);
    case (id)
      4'd0:    return "reset";
      4'd1:    return "add_sub_directed";
      4'd2:    return "add_sub_random";
      4'd3:    return "compare";
      4'd4:    return "overflow";
      4'd5:    return "throughput";
      default: return "unknown";
    endcase
  endfunction

  ////////////////////////////////
  // reference model
  ////////////////////////////////
  // returns {packed result, overflow} of one lane
  function automatic logic [16:0] add_lane(input logic [15:0] x, input logic [15:0] y,
                                           input logic sub);
    int          ex;
    int          ey;
    int          mx;
    int          my;
    int          big_e;
    int          big_m;
    int          small_m;
    int          sum;
    int          p;
    int          e_out;
    logic        sx;
    logic        sy;
    logic        s_out;
    logic [31:0] t;
    ex = int'(x[14:10]);
    ey = int'(y[14:10]);
    mx = (ex == 0) ? 0 : (1024 + int'(x[9:0])) * 8; // hidden bit and 3 guard bits
    my = (ey == 0) ? 0 : (1024 + int'(y[9:0])) * 8;
    sx = (ex != 0) && x[15];
    sy = ((ey != 0) && y[15]) ^ sub;
    if (mx == 0 && my == 0) begin
      return 17'b0;
    end
    // the larger magnitude sets sign and exponent and x wins ties
    if ((ey != 0) && (ex == 0 || y[14:0] > x[14:0])) begin
      big_e   = ey;
      big_m   = my;
      small_m = mx >> (ey - ex);
      s_out   = sy;
    end else begin
      big_e   = ex;
      big_m   = mx;
      small_m = my >> (ex - ey);
      s_out   = sx;
    end
    sum = (sx == sy) ? big_m + small_m : big_m - small_m;
    if (sum == 0) begin
      return 17'b0;
    end
    p = 0;
    for (int i = 0; i < 15; i++) begin
      if (sum[i]) p = i;
    end
    e_out = big_e + p - 13;
    t     = 32'(sum) << (31 - p); // leading one lands in bit 31
    if (e_out < 1) begin
      return {s_out, 15'b0, 1'b0};
    end
    if (e_out > 30) begin
      return {s_out, 5'h1f, 10'b0, 1'b1};
    end
    return {s_out, 5'(e_out), t[30:21], 1'b0};
  endfunction

  function automatic logic [FLAG_W-1:0] compare_lane(input logic [15:0] x,
                                                     input logic [15:0] y);
    int                kx;
    int                ky;
    logic [FLAG_W-1:0] f;
    kx = (x[14:10] == 5'd0) ? 0 : int'(x[14:0]);
    ky = (y[14:10] == 5'd0) ? 0 : int'(y[14:0]);
    if (x[15]) kx = -kx;
    if (y[15]) ky = -ky;
    f          = '0;
    f[FLAG_EQ] = (kx == ky);
    f[FLAG_LT] = (kx < ky);
    f[FLAG_GT] = (kx > ky);
    return f;
  endfunction

  function automatic logic [36:0] ref_fpu(input fpu_op_e o, input logic [31:0] x,
                                          input logic [31:0] y);
    logic [16:0]       lo;
    logic [16:0]       hi;
    logic [FLAG_W-1:0] f;
    lo = add_lane(x[15:0], y[15:0], o != OP_ADD);
    hi = add_lane(x[31:16], y[31:16], o != OP_ADD);
    f  = '0;
    if (o == OP_CMP_LO) f = compare_lane(x[15:0], y[15:0]);
    if (o == OP_CMP_HI) f = compare_lane(x[31:16], y[31:16]);
    return {hi[16:1], lo[16:1], f, hi[0], lo[0]};
  endfunction

  ////////////////////////////////
  // monitor
  ////////////////////////////////
  always @(posedge clk) begin
    if (rst) begin
      if (rst_seen && out_valid !== 1'b0) begin
        $display("out_valid is not low during reset at cycle %0d", cyc);
        n_protocol++;
      end
      rst_seen = 1'b1;
    end else begin
      if (out_valid === 1'b1) begin
        if (exp_q.size() == 0) begin
          $display("out_valid at cycle %0d with no operation outstanding", cyc);
          n_protocol++;
        end else begin
          if (due_q[0] != cyc) begin
            $display("%s: out_valid at cycle %0d, expected at cycle %0d",
                     test_name(id_q[0]), cyc, due_q[0]);
            n_protocol++;
          end
          if ({result, flags, ovf} !== exp_q[0]) begin
            // values shown as result/flags/ovf
            $display("Mismatch in %s: expected %h/%b/%b, actual %h/%b/%b",
                     test_name(id_q[0]), exp_q[0][36:5], exp_q[0][4:2], exp_q[0][1:0],
                     result, flags, ovf);
            n_mismatch++;
          end
          void'(exp_q.pop_front());
          void'(due_q.pop_front());
          void'(id_q.pop_front());
        end
      end else if (out_valid !== 1'b0) begin
        $display("out_valid is unknown at cycle %0d", cyc);
        n_protocol++;
      end else if (exp_q.size() != 0 && due_q[0] <= cyc) begin
        $display("%s: no out_valid for the operation due at cycle %0d",
                 test_name(id_q[0]), due_q[0]);
        n_protocol++;
        void'(exp_q.pop_front());
        void'(due_q.pop_front());
        void'(id_q.pop_front());
      end
      if (in_valid) begin
        exp_q.push_back(ref_fpu(op, a, b));
        due_q.push_back(cyc + LAT);
        id_q.push_back(test_id);
      end
    end
    n_pending = exp_q.size();
    cyc++;
  end

endmodule

// ==== tb_fpu_pair.sv ====
/*
  testbench top for the fp16 pair unit
  LFSR stimulus, directed and random tests and the final report
*/
module tb_fpu_pair import fpu_pkg::*; ();

  logic              clk;
  logic              rst;
  logic              in_valid;
  fpu_op_e           op;
  logic [WORD_W-1:0] a;
  logic [WORD_W-1:0] b;
  logic              out_valid;
  logic [WORD_W-1:0] result;
  logic [FLAG_W-1:0] flags;
  logic [1:0]        ovf;
  logic [3:0]        test_id;
  int                mismatch_count;
  int                protocol_count;
  int                pending;
  logic [31:0]       lfsr = 32'h9514;

  tb_clock i_clock (.clk(clk), .rst(rst));

  fpu_pair_top i_fpu_pair_top (
    .clk(clk), .rst(rst), .in_valid(in_valid), .op(op), .a(a), .b(b),
    .out_valid(out_valid), .result(result), .flags(flags), .ovf(ovf)
  );

  fpu_checker i_checker (
    .clk(clk), .rst(rst), .test_id(test_id), .in_valid(in_valid), .op(op), .a(a), .b(b),
    .out_valid(out_valid), .result(result), .flags(flags), .ovf(ovf),
    .mismatch_count(mismatch_count), .protocol_count(protocol_count), .pending(pending)
  );

  // fibonacci, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
  endtask

  task automatic rand_word(output logic [31:0] v);
    logic [31:0] r;
    for (int i = 0; i < 2; i++) begin
      take_bits(16, r);
      if (r[14:10] == 5'd0) r[14:10] = 5'd1; // keep exponents in 1..30
      if (r[14:10] == 5'd31) r[14:10] = 5'd30;
      v = {r[15:0], v[31:16]};
    end
  endtask

  task automatic issue(input fpu_op_e o, input logic [31:0] x, input logic [31:0] y);
    @(negedge clk);
    in_valid = 1'b1;
    op       = o;
    a        = x;
    b        = y;
  endtask

  task automatic idle();
    @(negedge clk);
    in_valid = 1'b0;
  endtask

  task automatic wait_reset(output bit ok);
    ok = 1'b0;
    for (int i = 0; i < 10 && !ok; i++) begin
      @(negedge clk);
      ok = !rst;
    end
    if (!ok) $display("timed out waiting for reset to be released");
  endtask

  task automatic drain(output bit ok);
    ok = 1'b0;
    for (int i = 0; i < LAT + 20 && !ok; i++) begin
      idle();
      ok = (pending == 0);
    end
    if (!ok) $display("timed out waiting for %0d outstanding results", pending);
  endtask

  task automatic run_all(output bit ok);
    logic [31:0] x;
    logic [31:0] y;
    logic [31:0] r;
    wait_reset(ok);
    if (!ok) return;
    test_id = 4'd0;
    repeat (4) idle(); // nothing issued, out_valid must stay low

    test_id = 4'd1;
    issue(OP_ADD, 32'h3c00_3c00, 32'h3c00_bc00); // lo cancels to +0
    issue(OP_SUB, 32'h4000_4200, 32'h4000_4200);
    issue(OP_SUB, 32'h3e00_0400, 32'h3c00_0401); // lo underflows to -0
    issue(OP_ADD, 32'h3c00_3c00, 32'h1000_0001);
    issue(OP_SUB, 32'hc000_3800, 32'h3800_c000);
    drain(ok);
    if (!ok) return;

    test_id = 4'd2;
    for (int i = 0; i < 60; i++) begin
      rand_word(x);
      take_bits(9, r);
      if (r[8]) y = x ^ {1'b1, 11'b0, r[7:4], 1'b1, 11'b0, r[3:0]}; // near cancel
      else rand_word(y);
      take_bits(1, r);
      issue(r[0] ? OP_SUB : OP_ADD, x, y);
    end
    drain(ok);
    if (!ok) return;

    test_id = 4'd3;
    issue(OP_CMP_LO, 32'h4000_3c00, 32'h3c00_4000); // lo lt, hi gt
    issue(OP_CMP_HI, 32'h4000_3c00, 32'h3c00_4000);
    issue(OP_CMP_HI, 32'h8000_bc00, 32'h0000_c000); // signed zeros equal
    issue(OP_CMP_LO, 32'h8000_bc00, 32'h0000_c000);
    issue(OP_CMP_LO, 32'hc000_3c01, 32'hbc00_3c01);
    issue(OP_CMP_HI, 32'hc000_3c01, 32'hbc00_3c01);
    for (int i = 0; i < 20; i++) begin
      rand_word(x);
      rand_word(y);
      take_bits(1, r);
      issue(r[0] ? OP_CMP_HI : OP_CMP_LO, x, y);
    end
    drain(ok);
    if (!ok) return;

    test_id = 4'd4;
    issue(OP_ADD, 32'h7bff_3c00, 32'h7bff_3c00); // hi only
    issue(OP_ADD, 32'h3c00_fbff, 32'h3c00_fbff); // lo only, negative
    issue(OP_SUB, 32'h7800_7c00, 32'hf800_0400); // both lanes
    drain(ok);
    if (!ok) return;

    test_id = 4'd5;
    for (int i = 0; i < 40; i++) begin
      rand_word(x);
      rand_word(y);
      take_bits(4, r);
      issue(fpu_op_e'(r[3:2]), x, y);
      if (r[1:0] == 2'd0) idle(); // random gap
    end
    drain(ok);
    if (!ok) return;
    repeat (LAT + 2) idle();
  endtask

  initial begin
    bit ok;
    in_valid = 1'b0;
    op       = OP_ADD;
    a        = '0;
    b        = '0;
    test_id  = 4'd0;
    run_all(ok);
    $display("errors: %0d mismatches, %0d protocol, %0d timeouts",
             mismatch_count, protocol_count, ok ? 0 : 1);
    if (ok && mismatch_count == 0 && protocol_count == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// ==== all.f ====
fpu_pkg.sv
fp16_align.sv
fp16_normalize.sv
fp16_lane.sv
fpu_ctrl.sv
fpu_pair_top.sv
tb_clock.sv
fpu_checker.sv
tb_fpu_pair.sv

// ==== Makefile ====
# Verilator build and run for the fp16 pair unit

VERILATOR ?= verilator
TOP       ?= tb_fpu_pair
VFLAGS    ?= --binary --timing -Wno-fatal
OBJ_DIR   ?= obj_dir
FILELIST  ?= all.f

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list targets and variables"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP VFLAGS OBJ_DIR FILELIST"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "Simulation finished: PASS"

clean:
	rm -rf $(OBJ_DIR)
